//--- sim.f
verilog/eeprom_pkg.sv
verilog/bus_bit_if.sv
verilog/i2c_bit_engine.sv
verilog/eeprom_sequencer.sv
verilog/eeprom_ctrl.sv
sim/eeprom_model.sv
sim/tb_eeprom_ctrl.sv

//--- sim/tb_eeprom_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module tb_eeprom_ctrl;

    localparam int CLK_DIV    = 4;
    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYC  = 16;
    localparam int N_ROWS     = 17;
    // 40 bit times per row plus reset
    localparam int WATCHDOG_CYC = N_ROWS * 40 * 2 * CLK_DIV + RESET_CYC;

    localparam logic [1:0] K_WRITE   = 2'd0;
    localparam logic [1:0] K_READ    = 2'd1;
    localparam logic [1:0] K_WR_BUSY = 2'd2;   // read with a wr strobe while busy
    localparam logic [1:0] K_WR_RD   = 2'd3;   // wr and rd together

    typedef struct packed {
        logic [1:0]                    kind;
        logic [eeprom_pkg::ADDR_W-1:0] addr;
        logic [eeprom_pkg::DATA_W-1:0] data;
        logic                          rnd;   // random byte instead of data
        logic                          absent;
        logic                          exp_nack;
    } row_t;

    logic                          CLK;
    logic                          RESET;
    logic                          wr;
    logic                          rd;
    logic [eeprom_pkg::ADDR_W-1:0] addr;
    logic [eeprom_pkg::DATA_W-1:0] wr_data;
    logic [eeprom_pkg::DATA_W-1:0] rd_data;
    logic                          busy;
    logic                          ack;
    logic                          nack;
    logic                          scl;
    wire                           sda;
    logic                          model_absent;

    row_t                          rows [0:N_ROWS-1];
    int                            n_rows;
    logic [eeprom_pkg::DATA_W-1:0] ref_mem [0:(1 << eeprom_pkg::ADDR_W)-1];

    pullup (sda);

    eeprom_ctrl #(
        .CLK_DIV (CLK_DIV)
    ) i_eeprom_ctrl (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .busy    (busy),
        .ack     (ack),
        .nack    (nack),
        .scl     (scl),
        .sda     (sda)
    );

    eeprom_model i_eeprom_model (
        .scl    (scl),
        .sda    (sda),
        .absent (model_absent)
    );

    initial
        CLK = 1'b0;

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_data(input string name, input logic [eeprom_pkg::DATA_W-1:0] got,
                              input logic [eeprom_pkg::DATA_W-1:0] exp);
        if (got !== exp)
            fail_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_status(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic add_row(input logic [1:0] kind, input logic [10:0] a, input logic [7:0] d,
                           input logic rnd, input logic absent, input logic exp_nack);
        rows[n_rows].kind     = kind;
        rows[n_rows].addr     = a;
        rows[n_rows].data     = d;
        rows[n_rows].rnd      = rnd;
        rows[n_rows].absent   = absent;
        rows[n_rows].exp_nack = exp_nack;
        n_rows = n_rows + 1;
    endtask

    task automatic apply_row(input row_t row);
        logic [31:0]                   rnd_word;
        logic [eeprom_pkg::DATA_W-1:0] d;
        rnd_word = $urandom;
        d = row.rnd ? rnd_word[eeprom_pkg::DATA_W-1:0] : row.data;
        @(negedge CLK);
        model_absent = row.absent;
        addr         = row.addr;
        wr_data      = d;
        wr           = (row.kind == K_WRITE) || (row.kind == K_WR_RD);
        rd           = (row.kind != K_WRITE);
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
        check_status("busy", busy, 1'b1);
        check_status("nack", nack, 1'b0);
        if (row.kind == K_WR_BUSY)
        begin
            repeat (3 * CLK_DIV) @(negedge CLK);
            check_status("busy", busy, 1'b1);
            wr      = 1'b1;   // must be ignored
            wr_data = ~ref_mem[row.addr];
            @(negedge CLK);
            wr = 1'b0;
        end
        while (ack !== 1'b1)
            @(negedge CLK);
        check_status("busy", busy, 1'b0);
        check_status("nack", nack, row.exp_nack);
        if (row.kind == K_READ || row.kind == K_WR_BUSY)
            check_data("rd_data", rd_data, ref_mem[row.addr]);
        else if (!row.exp_nack)
            ref_mem[row.addr] = d;
        model_absent = 1'b0;
    endtask

    initial
    begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        fail_run("Timeout: the transfer never finished before the watchdog ran out");
    end

    initial
    begin
        void'($urandom(32'h79cc));
        RESET        = 1'b1;
        wr           = 1'b0;
        rd           = 1'b0;
        addr         = '0;
        wr_data      = '0;
        model_absent = 1'b0;
        n_rows       = 0;
        for (int i = 0; i < (1 << eeprom_pkg::ADDR_W); i++)
            ref_mem[i] = 8'hff;

        add_row(K_WRITE,   11'h055, 8'h3c, 1'b0, 1'b0, 1'b0);
        add_row(K_READ,    11'h055, 8'h00, 1'b0, 1'b0, 1'b0);
        add_row(K_WRITE,   11'h155, 8'hc3, 1'b0, 1'b0, 1'b0);   // same low byte in block 1
        add_row(K_WRITE,   11'h755, 8'h5a, 1'b0, 1'b0, 1'b0);
        add_row(K_READ,    11'h055, 8'h00, 1'b0, 1'b0, 1'b0);
        add_row(K_READ,    11'h155, 8'h00, 1'b0, 1'b0, 1'b0);
        add_row(K_READ,    11'h755, 8'h00, 1'b0, 1'b0, 1'b0);
        add_row(K_READ,    11'h355, 8'h00, 1'b0, 1'b0, 1'b0);   // never written
        add_row(K_WRITE,   11'h2a0, 8'h00, 1'b1, 1'b1, 1'b1);   // no slave
        add_row(K_READ,    11'h2a0, 8'h00, 1'b0, 1'b0, 1'b0);
        add_row(K_WRITE,   11'h0f0, 8'h00, 1'b1, 1'b0, 1'b0);
        add_row(K_WR_BUSY, 11'h0f0, 8'h00, 1'b0, 1'b0, 1'b0);
        add_row(K_READ,    11'h0f0, 8'h00, 1'b0, 1'b0, 1'b0);
        add_row(K_WR_RD,   11'h4c7, 8'h00, 1'b1, 1'b0, 1'b0);
        add_row(K_READ,    11'h4c7, 8'h00, 1'b0, 1'b0, 1'b0);
        add_row(K_WRITE,   11'h7ff, 8'h00, 1'b1, 1'b0, 1'b0);
        add_row(K_READ,    11'h7ff, 8'h00, 1'b0, 1'b0, 1'b0);

        repeat (RESET_CYC)
        begin
            @(negedge CLK);
            check_status("busy", busy, 1'b0);
            check_status("ack", ack, 1'b0);
            check_status("nack", nack, 1'b0);
            check_status("scl", scl, 1'b1);
        end
        RESET = 1'b0;
        @(negedge CLK);
        check_status("busy", busy, 1'b0);
        check_status("ack", ack, 1'b0);
        check_status("nack", nack, 1'b0);
        check_status("scl", scl, 1'b1);
        check_status("sda", sda, 1'b1);   // released
        check_data("rd_data", rd_data, 8'h00);

        for (int r = 0; r < N_ROWS; r++)
            apply_row(rows[r]);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/eeprom_model.sv
`timescale 1ns/10ps
`default_nettype none

module eeprom_model (
    input  wire scl,
    inout  wire sda,
    input  wire absent   // never acknowledge
);

    localparam int ST_IDLE  = 0;
    localparam int ST_CTRL  = 1;
    localparam int ST_ADDR  = 2;
    localparam int ST_WDATA = 3;
    localparam int ST_RDATA = 4;

    localparam int DEPTH = 1 << eeprom_pkg::ADDR_W;

    logic [eeprom_pkg::DATA_W-1:0] mem [0:DEPTH-1];
    logic [eeprom_pkg::DATA_W-1:0] shreg;
    logic [eeprom_pkg::ADDR_W-1:0] ptr;
    logic [2:0]                    block;
    eeprom_pkg::ctrl_byte_u        ctrl;
    logic                          drive_low;
    int                            state;
    int                            next_state;
    int                            bit_cnt;   // 8 is the ack slot, -1 right after start

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        drive_low  = 1'b0;
        state      = ST_IDLE;
        next_state = ST_IDLE;
        bit_cnt    = 0;
        ptr        = '0;
        block      = '0;
        for (int i = 0; i < DEPTH; i++)
            mem[i] = 8'hff;   // erased
    end

    // a full byte came in, decide on the acknowledge
    task automatic take_byte();
        case (state)
            ST_CTRL:
            begin
                ctrl.raw = shreg;
                if (absent || ctrl.field.dev_type != eeprom_pkg::DEV_TYPE)
                begin
                    drive_low  = 1'b0;
                    next_state = ST_IDLE;
                end
                else
                begin
                    drive_low = 1'b1;
                    block     = ctrl.field.block;
                    if (ctrl.field.rw)
                    begin
                        ptr        = {block, ptr[eeprom_pkg::DATA_W-1:0]};
                        next_state = ST_RDATA;
                    end
                    else
                        next_state = ST_ADDR;
                end
            end
            ST_ADDR:
            begin
                ptr        = {block, shreg};
                drive_low  = 1'b1;
                next_state = ST_WDATA;
            end
            default:
            begin
                mem[ptr]   = shreg;   // single byte write, no page roll
                drive_low  = 1'b1;
                next_state = ST_IDLE;
            end
        endcase
    endtask

    // start or repeated start
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            state     = ST_CTRL;
            bit_cnt   = -1;
            drive_low = 1'b0;
        end
    end

    // stop
    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            state     = ST_IDLE;
            drive_low = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (state != ST_IDLE && state != ST_RDATA && bit_cnt >= 0 && bit_cnt < 8)
            shreg = {shreg[eeprom_pkg::DATA_W-2:0], sda !== 1'b0};
    end

    always @(negedge scl)
    begin
        if (state == ST_IDLE)
            drive_low = 1'b0;
        else if (bit_cnt == 8)
        begin
            drive_low = 1'b0;   // ack slot over
            bit_cnt   = 0;
            state     = next_state;
            if (state == ST_RDATA)
            begin
                shreg     = mem[ptr];
                drive_low = !shreg[7];
            end
        end
        else if (bit_cnt == 7)
        begin
            bit_cnt = 8;
            if (state == ST_RDATA)
            begin
                drive_low  = 1'b0;   // master acks or not
                next_state = ST_IDLE;
            end
            else
                take_byte();
        end
        else
        begin
            bit_cnt = bit_cnt + 1;
            if (state == ST_RDATA)
                drive_low = !shreg[7 - bit_cnt];
        end
    end

endmodule

`default_nettype wire

//--- verilog/eeprom_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module eeprom_ctrl #(
    parameter int CLK_DIV = 4
) (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [eeprom_pkg::DATA_W-1:0] wr_data,
    output logic [eeprom_pkg::DATA_W-1:0] rd_data,
    output logic                          busy,
    output logic                          ack,
    output logic                          nack,
    output logic                          scl,
    inout  wire                           sda
);

    logic sda_low;

    bus_bit_if bus ();

    // open drain, pull-up sits outside
    assign sda = sda_low ? 1'b0 : 1'bz;

    eeprom_sequencer i_eeprom_sequencer (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .busy    (busy),
        .ack     (ack),
        .nack    (nack),
        .bus     (bus.seq)
    );

    i2c_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) i_i2c_bit_engine (
        .CLK     (CLK),
        .RESET   (RESET),
        .sda_in  (sda),
        .scl     (scl),
        .sda_low (sda_low),
        .bus     (bus.eng)
    );

endmodule

`default_nettype wire

//--- verilog/eeprom_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module eeprom_sequencer (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [eeprom_pkg::DATA_W-1:0] wr_data,
    output logic [eeprom_pkg::DATA_W-1:0] rd_data,
    output logic                          busy,
    output logic                          ack,
    output logic                          nack,
    bus_bit_if.seq                        bus
);

    // one-hot states
    localparam logic [9:0] S_IDLE       = 10'b00_0000_0001;
    localparam logic [9:0] S_START      = 10'b00_0000_0010;
    localparam logic [9:0] S_CTRL_WRITE = 10'b00_0000_0100;
    localparam logic [9:0] S_ADDR_WRITE = 10'b00_0000_1000;
    localparam logic [9:0] S_DATA_WRITE = 10'b00_0001_0000;
    localparam logic [9:0] S_RESTART    = 10'b00_0010_0000;
    localparam logic [9:0] S_CTRL_READ  = 10'b00_0100_0000;
    localparam logic [9:0] S_DATA_READ  = 10'b00_1000_0000;
    localparam logic [9:0] S_STOP       = 10'b01_0000_0000;
    localparam logic [9:0] S_DONE       = 10'b10_0000_0000;

    logic [9:0]                    state;
    logic                          is_read;   // latched request
    logic [eeprom_pkg::ADDR_W-1:0] addr_q;
    logic [eeprom_pkg::DATA_W-1:0] data_q;
    logic                          accept;
    logic                          byte_out;
    eeprom_pkg::ctrl_byte_u        ctrl;

    assign busy = (state != S_IDLE) && (state != S_DONE);
    assign ack  = (state == S_DONE);

    // new request only while busy is low, wr wins over rd
    assign accept = !busy && (wr || rd);

    // states that shift a byte out and check the slave ack
    assign byte_out = (state == S_CTRL_WRITE) || (state == S_ADDR_WRITE) ||
                      (state == S_DATA_WRITE) || (state == S_CTRL_READ);

    assign bus.master_ack = 1'b0;   // single byte read ends with nack

    always_comb
    begin
        ctrl.field.dev_type = eeprom_pkg::DEV_TYPE;
        ctrl.field.block    = addr_q[eeprom_pkg::ADDR_W-1:eeprom_pkg::DATA_W];
        ctrl.field.rw       = (state == S_CTRL_READ);
    end

    always_comb
    begin
        case (state)
            S_START, S_RESTART:
                bus.cmd = eeprom_pkg::CMD_START;
            S_CTRL_WRITE, S_ADDR_WRITE, S_DATA_WRITE, S_CTRL_READ:
                bus.cmd = eeprom_pkg::CMD_WRITE;
            S_DATA_READ:
                bus.cmd = eeprom_pkg::CMD_READ;
            default:
                bus.cmd = eeprom_pkg::CMD_STOP;
        endcase
    end

    always_comb
    begin
        case (state)
            S_CTRL_WRITE, S_CTRL_READ:
                bus.tx_byte = ctrl.raw;
            S_ADDR_WRITE:
                bus.tx_byte = addr_q[eeprom_pkg::DATA_W-1:0];
            S_DATA_WRITE:
                bus.tx_byte = data_q;
            default:
                bus.tx_byte = '0;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            is_read <= !wr;
            addr_q  <= addr;
            data_q  <= wr_data;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state         <= S_IDLE;
            bus.cmd_valid <= 1'b0;
            nack          <= 1'b0;
            rd_data       <= '0;
        end
        else
        begin
            // issue the next command one cycle after done, none after stop
            bus.cmd_valid <= accept || (bus.done && state != S_STOP);

            if (bus.done && byte_out && bus.slave_nack)
                nack <= 1'b1;

            if (accept)
            begin
                nack  <= 1'b0;
                state <= S_START;
            end
            else
            begin
                case (state)
                    S_START:
                        if (bus.done)
                            state <= S_CTRL_WRITE;
                    S_CTRL_WRITE:
                        if (bus.done)
                            state <= bus.slave_nack ? S_STOP : S_ADDR_WRITE;
                    S_ADDR_WRITE:
                        if (bus.done)
                        begin
                            if (bus.slave_nack)
                                state <= S_STOP;
                            else if (is_read)
                                state <= S_RESTART;   // dummy write done, turn around
                            else
                                state <= S_DATA_WRITE;
                        end
                    S_DATA_WRITE:
                        if (bus.done)
                            state <= S_STOP;
                    S_RESTART:
                        if (bus.done)
                            state <= S_CTRL_READ;
                    S_CTRL_READ:
                        if (bus.done)
                            state <= bus.slave_nack ? S_STOP : S_DATA_READ;
                    S_DATA_READ:
                        if (bus.done)
                        begin
                            rd_data <= bus.rx_byte;
                            state   <= S_STOP;
                        end
                    S_STOP:
                        if (bus.done)
                            state <= S_DONE;
                    default:
                        state <= S_IDLE;   // idle, done, or lost encoding
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/i2c_bit_engine.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_bit_engine #(
    parameter int CLK_DIV = 4   // CLK cycles per half SCL period
) (
    input  logic   CLK,
    input  logic   RESET,
    input  logic   sda_in,
    output logic   scl,
    output logic   sda_low,
    bus_bit_if.eng bus
);

    // one bit is 2*CLK_DIV cycles, SCL low in the first half
    localparam int PH_W = $clog2(2 * CLK_DIV);

    localparam logic [PH_W-1:0] QTR_PH  = PH_W'((CLK_DIV - 1) / 2);
    localparam logic [PH_W-1:0] RISE_PH = PH_W'(CLK_DIV - 1);
    localparam logic [PH_W-1:0] TQTR_PH = PH_W'(CLK_DIV + (CLK_DIV - 1) / 2);
    localparam logic [PH_W-1:0] LAST_PH = PH_W'(2 * CLK_DIV - 1);

    localparam logic [3:0] ACK_BIT = 4'd8;

    logic                          active;
    logic [1:0]                    op;
    logic [PH_W-1:0]               phase;
    logic [3:0]                    bit_cnt;
    logic [eeprom_pkg::DATA_W-1:0] shifter;
    logic                          byte_op;
    logic                          last_bit;
    logic                          sda_next;   // level set at the quarter point

    assign byte_op  = (op == eeprom_pkg::CMD_WRITE) || (op == eeprom_pkg::CMD_READ);
    assign last_bit = (bit_cnt == ACK_BIT);

    assign bus.rx_byte = shifter;

    always_comb
    begin
        case (op)
            eeprom_pkg::CMD_START:
                sda_next = 1'b0;                   // release before SCL goes high
            eeprom_pkg::CMD_STOP:
                sda_next = 1'b1;                   // hold low until mid SCL high
            eeprom_pkg::CMD_WRITE:
                sda_next = !last_bit && !shifter[eeprom_pkg::DATA_W-1];
            default:
                sda_next = last_bit && bus.master_ack;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active         <= 1'b0;
            op             <= eeprom_pkg::CMD_STOP;
            phase          <= '0;
            bit_cnt        <= '0;
            scl            <= 1'b1;
            sda_low        <= 1'b0;
            bus.done       <= 1'b0;
            bus.slave_nack <= 1'b0;
        end
        else
        begin
            bus.done <= 1'b0;

            if (!active)
            begin
                if (bus.cmd_valid)
                begin
                    active  <= 1'b1;
                    op      <= bus.cmd;
                    phase   <= '0;
                    bit_cnt <= '0;
                    scl     <= 1'b0;   // every command opens with SCL low
                end
            end
            else
            begin
                if (phase == LAST_PH)
                    phase <= '0;
                else
                    phase <= phase + 1'b1;

                if (phase == QTR_PH)
                    sda_low <= sda_next;

                if (phase == RISE_PH)
                begin
                    scl <= 1'b1;
                    if (op == eeprom_pkg::CMD_WRITE && last_bit)
                        bus.slave_nack <= sda_in;   // high means no ack
                end

                // start and stop move SDA in the middle of SCL high
                if (phase == TQTR_PH && !byte_op)
                    sda_low <= (op == eeprom_pkg::CMD_START);

                if (phase == LAST_PH)
                begin
                    if (!byte_op || last_bit)
                    begin
                        active   <= 1'b0;   // SCL stays high until the next command
                        bus.done <= 1'b1;
                    end
                    else
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                        scl     <= 1'b0;
                    end
                end
            end
        end
    end

    // shared shift register, out MSB first for write, in MSB first for read
    always_ff @(posedge CLK)
    begin
        if (!active)
        begin
            if (bus.cmd_valid)
                shifter <= bus.tx_byte;
        end
        else if (op == eeprom_pkg::CMD_READ)
        begin
            if (phase == RISE_PH && !last_bit)
                shifter <= {shifter[eeprom_pkg::DATA_W-2:0], sda_in};
        end
        else if (op == eeprom_pkg::CMD_WRITE)
        begin
            if (phase == LAST_PH && !last_bit)
                shifter <= {shifter[eeprom_pkg::DATA_W-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

//--- verilog/bus_bit_if.sv
`timescale 1ns/10ps
`default_nettype none

interface bus_bit_if;

    logic [1:0]                    cmd;
    logic                          cmd_valid;    // one cycle per command
    logic [eeprom_pkg::DATA_W-1:0] tx_byte;
    logic                          master_ack;   // read only, drive 9th bit low
    logic [eeprom_pkg::DATA_W-1:0] rx_byte;      // valid with done after a read
    logic                          done;
    logic                          slave_nack;   // valid with done after a write

    modport seq (
        output cmd, cmd_valid, tx_byte, master_ack,
        input  rx_byte, done, slave_nack
    );

    modport eng (
        input  cmd, cmd_valid, tx_byte, master_ack,
        output rx_byte, done, slave_nack
    );

endinterface

`default_nettype wire

//--- verilog/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    localparam int ADDR_W = 11;   // 2K bytes
    localparam int DATA_W = 8;

    // device type code at the top of every control byte
    localparam logic [3:0] DEV_TYPE = 4'b1010;

    // commands from sequencer to bit engine
    localparam logic [1:0] CMD_START = 2'd0;   // also repeated start
    localparam logic [1:0] CMD_STOP  = 2'd1;
    localparam logic [1:0] CMD_WRITE = 2'd2;   // 8 bits out, ack sampled on 9th
    localparam logic [1:0] CMD_READ  = 2'd3;   // 8 bits in, 9th from master_ack

    // control byte, shifted as raw, built and decoded as fields
    typedef union packed {
        logic [DATA_W-1:0] raw;
        struct packed {
            logic [3:0] dev_type;
            logic [2:0] block;    // addr bits 10..8
            logic       rw;       // 1 = read
        } field;
    } ctrl_byte_u;

endpackage

`default_nettype wire
